//--- adc_pkg.sv
////////////////////
// shared widths, sample types and calibration constants
// for the two-channel analog input path
////////////////////

`default_nettype none

package adc_pkg;

  ////////////////////
  // widths
  ////////////////////

  // ADC and DAC words
  localparam int unsigned RAW_W  = 14;
  localparam int unsigned SMP_W  = 14;
  localparam int unsigned DAC_W  = 14;
  // calibration
  localparam int unsigned GAIN_W = 16;
  localparam int unsigned OFS_W  = 14;
  localparam int unsigned PRD_W  = SMP_W + GAIN_W;
  // configuration port
  localparam int unsigned ADR_W  = 4;
  localparam int unsigned CFG_W  = 16;

  ////////////////////
  // types
  ////////////////////

  // offset binary, straight from the converter
  typedef logic        [RAW_W-1:0]  raw_t;
  typedef logic signed [SMP_W-1:0]  sample_t;
  // fixed point, GAIN_FRAC fraction bits
  typedef logic signed [GAIN_W-1:0] gain_t;
  typedef logic signed [OFS_W-1:0]  offset_t;
  // full product before the shift
  typedef logic signed [PRD_W-1:0]  product_t;
  typedef logic        [DAC_W-1:0]  dac_t;
  typedef logic        [ADR_W-1:0]  cfg_addr_t;
  typedef logic        [CFG_W-1:0]  cfg_data_t;

  ////////////////////
  // constants
  ////////////////////

  localparam int unsigned GAIN_FRAC = 14;
  // unity gain, reset value of every gain register
  localparam gain_t   GAIN_ONE = gain_t'(1 << GAIN_FRAC);
  // saturation limits of the calibrated sample
  localparam sample_t SMP_MAX  = sample_t'(8191);
  localparam sample_t SMP_MIN  = sample_t'(-8192);
  // negative-slope DAC code for a zero sample
  localparam dac_t    DAC_ZERO = {1'b0, {(DAC_W-1){1'b1}}};

endpackage : adc_pkg

`default_nettype wire

//--- calib_regs.sv
////////////////////
// calibration register bank
// per-channel gain and offset written over a four-phase req/ack port
////////////////////

`timescale 1ns/1ns
`default_nettype none

module calib_regs
  import adc_pkg::*;
#(
  parameter int unsigned NCH = 2
)(
  input  wire                     adc_clk,
  input  wire                     top_rst,
  // configuration write port
  input  logic                    cfg_req_i,
  input  cfg_addr_t               cfg_addr_i,
  input  cfg_data_t               cfg_data_i,
  output logic                    cfg_ack_o,
  // calibration values, one pair per channel
  output gain_t     [NCH-1:0]     gain_o,
  output offset_t   [NCH-1:0]     offset_o
);

  ////////////////////
  // handshake FSM
  ////////////////////

  typedef enum logic {
    ST_IDLE,
    ST_ACKED
  } state_t;

  state_t state;

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        // new request only from idle so one write per request
        ST_IDLE:  if (cfg_req_i)  state <= ST_ACKED;
        // wait for the master to drop req
        ST_ACKED: if (!cfg_req_i) state <= ST_IDLE;
        default:  state <= ST_IDLE;
      endcase
    end
  end

  // ack follows the state register directly
  assign cfg_ack_o = (state == ST_ACKED);

  ////////////////////
  // address decode
  ////////////////////

  logic [2:0] wr_ch;
  logic       wr_sel;
  logic       wr_en;

  // even address gain, odd address offset
  assign wr_ch   = cfg_addr_i[ADR_W-1:1];
  assign wr_sel  = cfg_addr_i[0];
  // store on the edge that raises ack
  assign wr_en   = (state == ST_IDLE) && cfg_req_i;

  ////////////////////
  // register file
  ////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      for (int k = 0; k < NCH; k++) begin
        gain_o[k]   <= GAIN_ONE;
        offset_o[k] <= '0;
      end
    end else if (wr_en) begin
      // addresses past the last channel match no k and are dropped
      for (int k = 0; k < NCH; k++) begin
        if (wr_ch == 3'(k)) begin
          if (wr_sel) begin
            // offset uses the low bits only
            offset_o[k] <= offset_t'(cfg_data_i[OFS_W-1:0]);
          end else begin
            gain_o[k]   <= gain_t'(cfg_data_i);
          end
        end
      end
    end
  end

endmodule : calib_regs

`default_nettype wire

//--- adc_channel.sv
////////////////////
// one ADC channel: input register, offset binary to two's complement,
// gain multiply, shift, offset add and saturation
////////////////////

`timescale 1ns/1ns
`default_nettype none

module adc_channel
  import adc_pkg::*;
(
  input  wire      adc_clk,
  input  wire      top_rst,
  // raw converter word, new one every clock
  input  raw_t     raw_i,
  // calibration from the register bank
  input  gain_t    gain_i,
  input  offset_t  offset_i,
  // calibrated sample, 3 clocks after raw_i
  output sample_t  cal_o
);

  ////////////////////
  // stage 1: input register
  ////////////////////

  sample_t  smp_r;
  sample_t  smp_nxt;

  // top bit kept, rest inverted
  // negative slope of the analog front end folded in here
  assign smp_nxt = sample_t'({raw_i[RAW_W-1], ~raw_i[RAW_W-2:0]});

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      smp_r <= '0;
    end else begin
      smp_r <= smp_nxt;
    end
  end

  ////////////////////
  // stage 2: product register
  ////////////////////

  product_t prod_r;

  // both operands signed, extended to the full product width
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      prod_r <= '0;
    end else begin
      prod_r <= smp_r * gain_i;
    end
  end

  ////////////////////
  // stage 3: shift, offset, saturate
  ////////////////////

  product_t shift_w;
  product_t sum_w;
  sample_t  sat_w;
  sample_t  sat_r;

  // drop the fraction bits, sign preserved
  assign shift_w = prod_r >>> GAIN_FRAC;

  // offset added at full width, no wrap possible here
  assign sum_w   = shift_w + product_t'(offset_i);

  // clamp to the sample range
  always_comb begin
    if (sum_w > product_t'(SMP_MAX)) begin
      sat_w = SMP_MAX;
    end else if (sum_w < product_t'(SMP_MIN)) begin
      sat_w = SMP_MIN;
    end else begin
      sat_w = sample_t'(sum_w);
    end
  end

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      sat_r <= '0;
    end else begin
      sat_r <= sat_w;
    end
  end

  // to the DAC output stage
  assign cal_o = sat_r;

endmodule : adc_channel

`default_nettype wire

//--- dac_out_stage.sv
////////////////////
// DAC output stage: negative-slope re-encode and output register
////////////////////

`timescale 1ns/1ns
`default_nettype none

module dac_out_stage
  import adc_pkg::*;
#(
  parameter int unsigned NCH = 2
)(
  input  wire                 adc_clk,
  input  wire                 top_rst,
  // calibrated samples from every channel
  input  sample_t [NCH-1:0]   cal_i,
  // one DAC word per channel
  output dac_t    [NCH-1:0]   dac_dat_o
);

  ////////////////////
  // encode
  ////////////////////

  dac_t [NCH-1:0] dac_nxt;

  // sign kept, magnitude bits inverted
  // signed to unsigned plus slope flip in one step
  always_comb begin
    for (int k = 0; k < NCH; k++) begin
      dac_nxt[k] = {cal_i[k][SMP_W-1], ~cal_i[k][SMP_W-2:0]};
    end
  end

  ////////////////////
  // output register
  ////////////////////

  // comes out of reset showing the zero sample code
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      for (int k = 0; k < NCH; k++) begin
        dac_dat_o[k] <= DAC_ZERO;
      end
    end else begin
      dac_dat_o <= dac_nxt;
    end
  end

endmodule : dac_out_stage

`default_nettype wire

//--- adc_frontend_top.sv
////////////////////
// analog input path top level
// register bank, NCH calibrated channels and the DAC output stage
////////////////////

`timescale 1ns/1ns
`default_nettype none

module adc_frontend_top
  import adc_pkg::*;
#(
  // 1 to 8, limited by the 4-bit register address
  parameter int unsigned NCH = 2
)(
  input  wire                  adc_clk,
  input  wire                  top_rst,
  // ADC samples, offset binary, always valid
  input  raw_t    [NCH-1:0]    adc_dat_i,
  // configuration write port
  input  logic                 cfg_req_i,
  input  cfg_addr_t            cfg_addr_i,
  input  cfg_data_t            cfg_data_i,
  output logic                 cfg_ack_o,
  // DAC words, 4 clocks after the ADC sample
  output dac_t    [NCH-1:0]    dac_dat_o
);

  ////////////////////
  // local wires
  ////////////////////

  // calibration per channel
  gain_t   [NCH-1:0] gain;
  offset_t [NCH-1:0] offset;
  // calibrated samples toward the DAC
  sample_t [NCH-1:0] cal;

  ////////////////////
  // register bank
  ////////////////////

  calib_regs #(
    .NCH        (NCH)
  ) calib_regs_i (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .cfg_req_i  (cfg_req_i),
    .cfg_addr_i (cfg_addr_i),
    .cfg_data_i (cfg_data_i),
    .cfg_ack_o  (cfg_ack_o),
    .gain_o     (gain),
    .offset_o   (offset)
  );

  ////////////////////
  // channels
  ////////////////////

  for (genvar k = 0; k < NCH; k++) begin : g_ch
    adc_channel adc_channel_i (
      .adc_clk  (adc_clk),
      .top_rst  (top_rst),
      .raw_i    (adc_dat_i[k]),
      .gain_i   (gain[k]),
      .offset_i (offset[k]),
      .cal_o    (cal[k])
    );
  end : g_ch

  ////////////////////
  // DAC output
  ////////////////////

  dac_out_stage #(
    .NCH       (NCH)
  ) dac_out_stage_i (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .cal_i     (cal),
    .dac_dat_o (dac_dat_o)
  );

endmodule : adc_frontend_top

`default_nettype wire

//--- tb_adc_frontend.sv
////////////////////
// testbench for the analog input path
// file driven stimulus, own model of calibration and DAC code
////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_adc_frontend
  import adc_pkg::*;
();

  localparam int    NCH       = 2;
  localparam int    LATENCY   = 4;
  localparam int    ACK_WAIT  = 50;
  localparam string STIM_FILE = "adc_frontend_stimulus.txt";

  ////////////////////
  // DUT and clock
  ////////////////////

  logic            adc_clk;
  logic            top_rst;
  raw_t [NCH-1:0]  adc_dat;
  logic            cfg_req;
  cfg_addr_t       cfg_addr;
  cfg_data_t       cfg_data;
  logic            cfg_ack;
  dac_t [NCH-1:0]  dac_dat;

  adc_frontend_top #(
    .NCH        (NCH)
  ) dut_i (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .adc_dat_i  (adc_dat),
    .cfg_req_i  (cfg_req),
    .cfg_addr_i (cfg_addr),
    .cfg_data_i (cfg_data),
    .cfg_ack_o  (cfg_ack),
    .dac_dat_o  (dac_dat)
  );

  // 10 ns period
  initial begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;
  end

  ////////////////////
  // model state and counters
  ////////////////////

  // copy of the register bank, built from the writes sent
  int    gain_m [NCH];
  int    ofs_m  [NCH];
  // samples in flight: falling edge when due, expected codes
  int    due_q  [$];
  int    exp0_q [$];
  int    exp1_q [$];
  int    tick;
  int    n_checks;
  int    n_errors;
  int    n_tests;
  int    t_checks;
  int    t_errors;
  string test_name;
  bit    test_open;

  // falling edge, all driving and sampling happens here
  task automatic next_fall();
    @(negedge adc_clk);
    tick++;
  endtask

  task automatic check_value(input logic [31:0] act, input logic [31:0] exp,
                             input string what);
    n_checks++;
    t_checks++;
    if (act !== exp) begin
      n_errors++;
      t_errors++;
      $display("MISMATCH at %0t ns: %s %s: got %0d, expected %0d",
               $time, test_name, what, act, exp);
    end
  endtask

  task automatic report_error(input string msg);
    n_errors++;
    t_errors++;
    $display("ERROR at %0t ns: %s", $time, msg);
  endtask

  task automatic end_test();
    if (test_open) begin
      $display("test %s: %0d checks, %0d errors", test_name, t_checks, t_errors);
      test_open = 1'b0;
    end
  endtask

  task automatic start_test(input string name);
    end_test();
    test_name = name;
    t_checks  = 0;
    t_errors  = 0;
    test_open = 1'b1;
    n_tests++;
  endtask

  ////////////////////
  // reference model
  ////////////////////

  // front end has negative slope both ways
  // raw 0 is full positive, sample +8191 is DAC code 0
  function automatic int expected_code(input int raw, input int gain, input int ofs);
    longint smp;
    longint sum;
    smp = 8191 - raw;
    // floor of product over 2^14, then offset
    sum = ((smp * gain) >>> 14) + ofs;
    if (sum > 8191) begin
      sum = 8191;
    end else if (sum < -8192) begin
      sum = -8192;
    end
    return int'(8191 - sum);
  endfunction

  task automatic model_write(input int addr, input int data);
    int d;
    if (addr < 2*NCH) begin
      if (addr % 2 == 0) begin
        gain_m[addr/2] = (data >= 32768) ? data - 65536 : data;
      end else begin
        // only 14 bits of offset
        d = data & 16'h3fff;
        ofs_m[addr/2] = (d >= 8192) ? d - 16384 : d;
      end
    end
  endtask

  ////////////////////
  // sample path
  ////////////////////

  task automatic check_due();
    int e0;
    int e1;
    while (due_q.size() > 0 && due_q[0] <= tick) begin
      void'(due_q.pop_front());
      e0 = exp0_q.pop_front();
      e1 = exp1_q.pop_front();
      check_value(dac_dat[0], e0, "channel 0 DAC code");
      check_value(dac_dat[1], e1, "channel 1 DAC code");
    end
  endtask

  task automatic drive_sample(input int r0, input int r1);
    next_fall();
    // output of 4 edges ago is visible now
    check_due();
    adc_dat[0] = raw_t'(r0);
    adc_dat[1] = raw_t'(r1);
    due_q.push_back(tick + LATENCY);
    exp0_q.push_back(expected_code(r0, gain_m[0], ofs_m[0]));
    exp1_q.push_back(expected_code(r1, gain_m[1], ofs_m[1]));
  endtask

  // drain the pipeline before a write or a new test
  task automatic flush_samples();
    int n;
    n = 0;
    while (due_q.size() > 0 && n < 2*LATENCY) begin
      next_fall();
      check_due();
      n++;
    end
    if (due_q.size() > 0) begin
      report_error("samples still in flight after the pipeline drain");
    end
  endtask

  ////////////////////
  // four-phase write
  ////////////////////

  task automatic write_cfg(input int addr, input int data);
    int n;
    next_fall();
    cfg_addr = cfg_addr_t'(addr);
    cfg_data = cfg_data_t'(data);
    cfg_req  = 1'b1;
    n = 0;
    while (cfg_ack !== 1'b1 && n < ACK_WAIT) begin
      next_fall();
      n++;
    end
    if (cfg_ack !== 1'b1) begin
      report_error($sformatf("cfg_ack_o did not rise within %0d cycles, address %0d",
                             ACK_WAIT, addr));
    end
    cfg_req = 1'b0;
    n = 0;
    while (cfg_ack !== 1'b0 && n < ACK_WAIT) begin
      next_fall();
      n++;
    end
    if (cfg_ack !== 1'b0) begin
      report_error($sformatf("cfg_ack_o did not fall within %0d cycles, address %0d",
                             ACK_WAIT, addr));
    end
    model_write(addr, data);
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    int                fd;
    int                r;
    int                a;
    int                b;
    bit                done;
    string             cmd;
    string             name;
    logic [8*256-1:0]  rest;
    // raw 8191 is the zero level, keeps the pipeline at zero
    for (int k = 0; k < NCH; k++) begin
      adc_dat[k] = raw_t'(8191);
      gain_m[k]  = 16384;
      ofs_m[k]   = 0;
    end
    cfg_req   = 1'b0;
    cfg_addr  = '0;
    cfg_data  = '0;
    top_rst   = 1'b1;
    tick      = 0;
    n_checks  = 0;
    n_errors  = 0;
    n_tests   = 0;
    test_open = 1'b0;
    for (int i = 0; i < 5; i++) begin
      next_fall();
    end
    top_rst = 1'b0;
    // behavior right out of reset, no sample driven yet
    start_test("reset");
    for (int i = 0; i < 3; i++) begin
      check_value(cfg_ack, 0, "cfg_ack_o after reset");
      check_value(dac_dat[0], 8191, "channel 0 zero code");
      check_value(dac_dat[1], 8191, "channel 1 zero code");
      next_fall();
    end
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      report_error("could not open the stimulus file adc_frontend_stimulus.txt");
    end else begin
      done = 1'b0;
      while (!done) begin
        r = $fscanf(fd, "%s", cmd);
        if (r != 1) begin
          done = 1'b1;
        end else if (cmd[0] == "#") begin
          r = $fgets(rest, fd);
        end else if (cmd == "T") begin
          r = $fscanf(fd, "%s", name);
          flush_samples();
          start_test(name);
        end else if (cmd == "W" || cmd == "S") begin
          r = $fscanf(fd, "%h %h", a, b);
          if (r != 2) begin
            report_error("stimulus line with missing numbers");
            done = 1'b1;
          end else if (cmd == "W") begin
            flush_samples();
            write_cfg(a, b);
          end else begin
            drive_sample(a, b);
          end
        end else begin
          report_error({"unknown command in the stimulus file: ", cmd});
          r = $fgets(rest, fd);
        end
      end
      $fclose(fd);
      flush_samples();
    end
    if (n_checks == 0) begin
      report_error("no checks were run");
    end
    end_test();
    $display("summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule : tb_adc_frontend

`default_nettype wire

//--- adc_frontend_stimulus.txt
# columns: W addr data (config write) | S raw_ch0 raw_ch1 (one sample each) | T name
# numbers in hex, raw words are 14-bit offset binary
T unity
S 0000 0000
S 1FFF 1FFF
S 2000 2000
S 3FFF 3FFF
S 0000 3FFF
S 3FFF 0000
S 1000 3000
S 2ABC 0123
S 1FFE 2001
S 0001 3FFE
# gain one half on channel 0, offset +100 on channel 1
T gain_offset
W 0 2000
W 3 0064
S 0000 0000
S 1FFF 1FFF
S 2000 2000
S 3FFF 3FFF
S 0F00 3100
S 1234 2345
S 0007 3FF8
# gain near two with offsets at both ends of the range
T saturate
W 0 7FFF
W 1 1000
W 2 7FFF
W 3 2000
S 0000 0000
S 3FFF 3FFF
S 1FFF 1FFF
S 1800 2800
S 0800 3800
S 2000 2000
# negative gains and a negative offset
T negative_gain
W 0 C000
W 1 0000
W 2 8000
W 3 3F9C
S 0000 0000
S 3FFF 3FFF
S 1FFF 2000
S 1000 3000
S 2FFF 0FFF
# out of range addresses, acked and dropped
T bad_address
W 4 1234
W 5 0FFF
W 8 0000
W F FFFF
S 0000 0000
S 3FFF 3FFF
S 1FFF 2000
S 1ABC 2DEF
S 0123 3210

//--- sim.f
adc_pkg.sv
calib_regs.sv
adc_channel.sv
dac_out_stage.sv
adc_frontend_top.sv
tb_adc_frontend.sv

//--- Makefile
# Verilator build and run of the analog input path testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       := tb_adc_frontend
FILELIST  := sim.f
OBJ_DIR   := obj_dir
PASS_MSG  := NO ERRORS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the result"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
